/* source/md_pkg.sv */
package md_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Grid and data widths
	////////////////////////////////////////////////////////////////////////////

	// One coordinate, packed position is {pos_z, pos_y, pos_x}
	localparam int coord_width = 16;
	localparam int pos_width = 3 * coord_width;

	// One cell coordinate, packed cell address is {cell_x, cell_y, cell_z}
	localparam int cell_id_width = 2;
	localparam int cell_addr_width = 3 * cell_id_width;

	// Grid size in cells
	localparam int grid_x = 2;
	localparam int grid_y = 2;
	localparam int grid_z = 1;
	localparam int cell_count = grid_x * grid_y * grid_z;

	// Address 0 holds the count, 1 and up the particles
	localparam int cache_depth = 64;
	localparam int addr_width = 6;

	////////////////////////////////////////////////////////////////////////////
	// Update controller states
	////////////////////////////////////////////////////////////////////////////

	typedef logic [1:0] upd_state_t;

	localparam upd_state_t upd_idle = 2'd0;
	localparam upd_state_t upd_collect = 2'd1;
	localparam upd_state_t upd_write_count = 2'd2;
	localparam upd_state_t upd_swap = 2'd3;

	// Packed cell address of a linear cell index, x fastest
	function automatic logic [cell_addr_width-1:0] cell_addr_of(input int unsigned idx);
		logic [cell_id_width-1:0] x;
		logic [cell_id_width-1:0] y;
		logic [cell_id_width-1:0] z;
		x = cell_id_width'(idx % grid_x);
		y = cell_id_width'((idx / grid_x) % grid_y);
		z = cell_id_width'(idx / (grid_x * grid_y));
		return {x, y, z};
	endfunction

	// Linear index of a packed cell address
	function automatic int unsigned cell_index_of(input logic [cell_addr_width-1:0] addr);
		return addr[3*cell_id_width-1 -: cell_id_width]
			+ grid_x * addr[2*cell_id_width-1 -: cell_id_width]
			+ grid_x * grid_y * addr[cell_id_width-1:0];
	endfunction

	// Cell address lies inside the grid bounds
	function automatic logic cell_in_grid(input logic [cell_addr_width-1:0] addr);
		return (addr[3*cell_id_width-1 -: cell_id_width] < grid_x)
			&& (addr[2*cell_id_width-1 -: cell_id_width] < grid_y)
			&& (addr[cell_id_width-1:0] < grid_z);
	endfunction

endpackage

/* source/cell_ram.sv */
`timescale 1ns/1ps

module cell_ram
(
	input  logic                         clk,
	input  logic [md_pkg::addr_width-1:0] address,
	input  logic [md_pkg::pos_width-1:0]  data,
	input  logic                         rden,
	input  logic                         wren,
	output logic [md_pkg::pos_width-1:0]  q
);

	// Storage for one bank
	logic [md_pkg::pos_width-1:0] mem [md_pkg::cache_depth];

	// Single port, a bank is either written or read in a given phase
	always_ff @(posedge clk)
	begin
		if (wren)
		begin
			mem[address] <= data;
		end
	end

	// One cycle read latency, q holds between reads
	always_ff @(posedge clk)
	begin
		if (rden)
		begin
			q <= mem[address];
		end
	end

endmodule

/* source/pos_cache.sv */
`timescale 1ns/1ps

module pos_cache
#(
	parameter logic [md_pkg::cell_addr_width-1:0] cell_id = '0
)
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              bc_enable,
	input  logic                              bc_valid,
	input  logic [md_pkg::pos_width-1:0]       bc_pos,
	input  logic [md_pkg::cell_addr_width-1:0] bc_dst_cell,
	input  logic                              rden,
	input  logic [md_pkg::addr_width-1:0]      rd_addr,
	output logic [md_pkg::pos_width-1:0]       out_pos
);

	////////////////////////////////////////////////////////////////////////////
	// Update controller
	////////////////////////////////////////////////////////////////////////////

	md_pkg::upd_state_t state;
	// Bank serving force evaluation reads
	logic bank_sel;
	// Particles appended this phase, one extra bit to see overflow
	logic [md_pkg::addr_width:0] part_count;

	// Write register toward the inactive bank
	logic wr_en;
	logic [md_pkg::addr_width-1:0] wr_addr;
	logic [md_pkg::pos_width-1:0] wr_data;

	logic hit;
	logic capture;
	logic count_write;

	// Broadcast particle targets this cell
	assign hit = bc_valid && (bc_dst_cell == cell_id);
	// First particle may already arrive on the idle cycle
	assign capture = hit && (state == md_pkg::upd_idle || state == md_pkg::upd_collect);
	assign count_write = (state == md_pkg::upd_write_count);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= md_pkg::upd_idle;
			bank_sel <= 1'b0;
			part_count <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= capture || count_write;
			if (capture)
			begin
				part_count <= part_count + 1'b1;
			end
			case (state)
				md_pkg::upd_idle:
				begin
					if (bc_enable)
					begin
						state <= md_pkg::upd_collect;
					end
				end
				md_pkg::upd_collect:
				begin
					// Enable held high for the whole phase
					if (!bc_enable)
					begin
						state <= md_pkg::upd_write_count;
					end
				end
				md_pkg::upd_write_count:
				begin
					state <= md_pkg::upd_swap;
				end
				default:
				begin
					// Count lands in RAM on this edge, then banks swap
					bank_sel <= !bank_sel;
					part_count <= '0;
					state <= md_pkg::upd_idle;
				end
			endcase
		end
	end

	// Particles go to address 1 and up, count goes to address 0
	always_ff @(posedge clk)
	begin
		if (count_write)
		begin
			wr_addr <= '0;
			wr_data <= {{(md_pkg::pos_width - md_pkg::addr_width - 1){1'b0}}, part_count};
		end
		else if (capture)
		begin
			wr_addr <= part_count[md_pkg::addr_width-1:0] + 1'b1;
			wr_data <= bc_pos;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bank steering
	////////////////////////////////////////////////////////////////////////////

	logic [md_pkg::addr_width-1:0] addr_0;
	logic [md_pkg::addr_width-1:0] addr_1;
	logic rden_0;
	logic rden_1;
	logic wren_0;
	logic wren_1;
	logic [md_pkg::pos_width-1:0] q_0;
	logic [md_pkg::pos_width-1:0] q_1;
	// Bank that served the last read
	logic q_sel;

	// Active bank reads, inactive bank takes the writes
	assign addr_0 = bank_sel ? wr_addr : rd_addr;
	assign addr_1 = bank_sel ? rd_addr : wr_addr;
	assign rden_0 = !bank_sel && rden;
	assign rden_1 = bank_sel && rden;
	assign wren_0 = bank_sel && wr_en;
	assign wren_1 = !bank_sel && wr_en;

	// Keeps a read that straddles the swap on its own bank
	always_ff @(posedge clk)
	begin
		if (rden)
		begin
			q_sel <= bank_sel;
		end
	end

	assign out_pos = q_sel ? q_1 : q_0;

	cell_ram bank_0
	(
		.clk(clk),
		.address(addr_0),
		.data(wr_data),
		.rden(rden_0),
		.wren(wren_0),
		.q(q_0)
	);

	cell_ram bank_1
	(
		.clk(clk),
		.address(addr_1),
		.data(wr_data),
		.rden(rden_1),
		.wren(wren_1),
		.q(q_1)
	);

	// Writes only follow a capture or the count cycle
	assert property (@(posedge clk) disable iff (rst)
		wr_en |-> ($past(state) == md_pkg::upd_collect)
			|| ($past(state) == md_pkg::upd_write_count)
			|| ($past(state) == md_pkg::upd_idle && $past(bc_valid)));

	// More particles than a bank holds
	assert property (@(posedge clk) disable iff (rst)
		part_count < md_pkg::cache_depth);

endmodule

/* source/cell_router.sv */
`timescale 1ns/1ps

module cell_router
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              motion_update_enable,
	input  logic                              in_valid,
	input  logic [md_pkg::pos_width-1:0]       in_pos,
	output logic                              bc_enable,
	output logic                              bc_valid,
	output logic [md_pkg::pos_width-1:0]       bc_pos,
	output logic [md_pkg::cell_addr_width-1:0] bc_dst_cell,
	output logic                              lost
);

	logic [md_pkg::cell_addr_width-1:0] dst_cell;
	logic in_grid;

	// Destination is the top bits of each coordinate, packed {x, y, z}
	assign dst_cell = {
		in_pos[md_pkg::coord_width-1 -: md_pkg::cell_id_width],
		in_pos[2*md_pkg::coord_width-1 -: md_pkg::cell_id_width],
		in_pos[3*md_pkg::coord_width-1 -: md_pkg::cell_id_width]
	};
	assign in_grid = md_pkg::cell_in_grid(dst_cell);

	// Framing and flags, one cycle behind the input
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bc_enable <= 1'b0;
			bc_valid <= 1'b0;
			lost <= 1'b0;
		end
		else
		begin
			bc_enable <= motion_update_enable;
			bc_valid <= motion_update_enable && in_valid && in_grid;
			// Out of grid particles are dropped here
			lost <= in_valid && !in_grid;
		end
	end

	// Broadcast payload
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			bc_pos <= in_pos;
			bc_dst_cell <= dst_cell;
		end
	end

	// Broadcasts stay inside the framed phase
	assert property (@(posedge clk) disable iff (rst) bc_valid |-> bc_enable);

	assert property (@(posedge clk) disable iff (rst) !(lost && bc_valid));

endmodule

/* source/pos_read_port.sv */
`timescale 1ns/1ps

module pos_read_port
(
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       rd_en,
	input  logic [md_pkg::cell_addr_width-1:0]          rd_cell,
	output logic [md_pkg::cell_count-1:0]               cache_rden,
	input  logic [md_pkg::cell_count*md_pkg::pos_width-1:0] cache_pos,
	output logic                                       rd_valid,
	output logic [md_pkg::pos_width-1:0]                rd_data
);

	// One-hot cache that was read last cycle
	logic [md_pkg::cell_count-1:0] rd_sel;

	// Off-grid cells enable no cache
	always_comb
	begin
		cache_rden = '0;
		if (rd_en && md_pkg::cell_in_grid(rd_cell))
		begin
			cache_rden[md_pkg::cell_index_of(rd_cell)] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_sel <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_sel <= cache_rden;
			rd_valid <= |cache_rden;
		end
	end

	// Cache q is already one cycle late, so the mux is combinational
	always_comb
	begin
		rd_data = '0;
		for (int i = 0; i < md_pkg::cell_count; i++)
		begin
			if (rd_sel[i])
			begin
				rd_data = cache_pos[i*md_pkg::pos_width +: md_pkg::pos_width];
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) $onehot0(cache_rden));

endmodule

/* source/pos_cache_grid.sv */
`timescale 1ns/1ps

module pos_cache_grid
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              motion_update_enable,
	input  logic                              in_valid,
	input  logic [md_pkg::pos_width-1:0]       in_pos,
	output logic                              lost,
	input  logic                              rd_en,
	input  logic [md_pkg::cell_addr_width-1:0] rd_cell,
	input  logic [md_pkg::addr_width-1:0]      rd_addr,
	output logic                              rd_valid,
	output logic [md_pkg::pos_width-1:0]       rd_data
);

	////////////////////////////////////////////////////////////////////////////
	// Broadcast from the router to all caches
	////////////////////////////////////////////////////////////////////////////

	logic bc_enable;
	logic bc_valid;
	logic [md_pkg::pos_width-1:0] bc_pos;
	logic [md_pkg::cell_addr_width-1:0] bc_dst_cell;

	// Read side, one enable and one data bus per cache
	logic [md_pkg::cell_count-1:0] cache_rden;
	logic [md_pkg::cell_count*md_pkg::pos_width-1:0] cache_pos;

	cell_router cell_router_i
	(
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.in_valid(in_valid),
		.in_pos(in_pos),
		.bc_enable(bc_enable),
		.bc_valid(bc_valid),
		.bc_pos(bc_pos),
		.bc_dst_cell(bc_dst_cell),
		.lost(lost)
	);

	pos_read_port pos_read_port_i
	(
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.cache_rden(cache_rden),
		.cache_pos(cache_pos),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// One cache per cell, x fastest
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < md_pkg::cell_count; i++)
	begin : g_cell
		pos_cache
		#(
			.cell_id(md_pkg::cell_addr_of(i))
		)
		pos_cache_i
		(
			.clk(clk),
			.rst(rst),
			.bc_enable(bc_enable),
			.bc_valid(bc_valid),
			.bc_pos(bc_pos),
			.bc_dst_cell(bc_dst_cell),
			.rden(cache_rden[i]),
			.rd_addr(rd_addr),
			.out_pos(cache_pos[i*md_pkg::pos_width +: md_pkg::pos_width])
		);
	end

endmodule

/* tests/pos_cache_grid_tb.sv */
`timescale 1ns/1ps

module pos_cache_grid_tb;

	////////////////////////////////////////////////////////////////////////////
	// Run length
	////////////////////////////////////////////////////////////////////////////

	localparam int rounds = 3;
	localparam int particles = 30;
	// Readback of every cell plus the reads issued during a round
	localparam int reads = particles + md_pkg::cell_count;
	localparam int reset_cycles = 16;
	localparam int limit_cycles = reset_cycles + rounds * (particles + reads + 40);

	logic clk;
	logic rst;
	logic motion_update_enable;
	logic in_valid;
	logic [md_pkg::pos_width-1:0] in_pos;
	logic lost;
	logic rd_en;
	logic [md_pkg::cell_addr_width-1:0] rd_cell;
	logic [md_pkg::addr_width-1:0] rd_addr;
	logic rd_valid;
	logic [md_pkg::pos_width-1:0] rd_data;

	// Expectations set along with the request, then delayed by one cycle
	logic [md_pkg::pos_width-1:0] exp_issue;
	logic oob_issue;
	logic [md_pkg::pos_width-1:0] exp_data;
	logic exp_valid;
	logic exp_lost;

	int seed;
	int errors;
	int read_count;
	int lost_count;

	// Reference banks, one queue per cell
	logic [md_pkg::pos_width-1:0] next_q [md_pkg::cell_count][$];
	logic [md_pkg::pos_width-1:0] cur_q [md_pkg::cell_count][$];

	pos_cache_grid pos_cache_grid_i
	(
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.in_valid(in_valid),
		.in_pos(in_pos),
		.lost(lost),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2;
			clk = !clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Linear cell of a position, -1 when outside the grid
	function automatic int cell_of_pos(input logic [md_pkg::pos_width-1:0] pos);
		int x;
		int y;
		int z;
		x = int'(pos[15:14]);
		y = int'(pos[31:30]);
		z = int'(pos[47:46]);
		if (x >= 2 || y >= 2 || z >= 1)
		begin
			return -1;
		end
		return x + 2 * y + 4 * z;
	endfunction

	// Packed {x, y, z} of a linear cell
	function automatic logic [md_pkg::cell_addr_width-1:0] cell_addr(input int c);
		logic [1:0] x;
		logic [1:0] y;
		logic [1:0] z;
		x = 2'(c % 2);
		y = 2'((c / 2) % 2);
		z = 2'(c / 4);
		return {x, y, z};
	endfunction

	// Mostly in-grid positions, about one in eight fully random
	task automatic make_pos(output logic [md_pkg::pos_width-1:0] pos);
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] z;
		logic [2:0] pick;
		x = 16'($random(seed));
		y = 16'($random(seed));
		z = 16'($random(seed));
		pick = 3'($random(seed));
		if (pick != 3'd0)
		begin
			x[15] = 1'b0;
			y[15] = 1'b0;
			z[15:14] = 2'b00;
		end
		pos = {z, y, x};
	endtask

	// Drives one read, expected value comes from the current bank
	task automatic set_read(input int c, input int addr);
		rd_en = 1'b1;
		rd_cell = cell_addr(c);
		rd_addr = md_pkg::addr_width'(addr);
		if (addr == 0)
		begin
			exp_issue = md_pkg::pos_width'(cur_q[c].size());
		end
		else
		begin
			exp_issue = cur_q[c][addr-1];
		end
		read_count++;
	endtask

	task automatic run_round(input int round);
		logic [md_pkg::pos_width-1:0] pos;
		int c;
		int rc;
		int addr;
		// Update phase, reads of the old bank mixed in after the first round
		for (int i = 0; i < particles; i++)
		begin
			@(negedge clk);
			motion_update_enable = 1'b1;
			make_pos(pos);
			in_valid = (3'($random(seed)) != 3'd0);
			in_pos = pos;
			c = cell_of_pos(pos);
			oob_issue = in_valid && (c < 0);
			if (in_valid && c >= 0)
			begin
				next_q[c].push_back(pos);
			end
			if (oob_issue)
			begin
				lost_count++;
			end
			rd_en = 1'b0;
			if (round > 0 && i % 3 == 0)
			begin
				rc = i % md_pkg::cell_count;
				addr = int'($unsigned($random(seed)) % (cur_q[rc].size() + 1));
				set_read(rc, addr);
			end
		end
		@(negedge clk);
		motion_update_enable = 1'b0;
		in_valid = 1'b0;
		oob_issue = 1'b0;
		rd_en = 1'b0;
		// Count write and bank swap
		repeat (8) @(negedge clk);
		for (int k = 0; k < md_pkg::cell_count; k++)
		begin
			cur_q[k] = next_q[k];
			next_q[k].delete();
		end
		// Back-to-back readback of count and particles of every cell
		for (int k = 0; k < md_pkg::cell_count; k++)
		begin
			for (int a = 0; a <= cur_q[k].size(); a++)
			begin
				@(negedge clk);
				set_read(k, a);
			end
		end
		@(negedge clk);
		rd_en = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			exp_valid <= 1'b0;
			exp_lost <= 1'b0;
		end
		else
		begin
			exp_valid <= rd_en;
			exp_lost <= oob_issue;
		end
		if (rd_en)
		begin
			exp_data <= exp_issue;
		end
	end

	// rd_valid exactly one cycle after each rd_en
	assert property (@(posedge clk) disable iff (rst) rd_valid == exp_valid)
	else
	begin
		$display("FAIL %0t rd_valid: got %b, expected %b", $time,
			$sampled(rd_valid), $sampled(exp_valid));
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst) rd_valid |-> (rd_data == exp_data))
	else
	begin
		$display("FAIL %0t rd_data: got %h, expected %h", $time,
			$sampled(rd_data), $sampled(exp_data));
		errors++;
	end

	// Lost pulse one cycle after an out-of-grid particle, low otherwise
	assert property (@(posedge clk) disable iff (rst) lost == exp_lost)
	else
	begin
		$display("FAIL %0t lost: got %b, expected %b", $time,
			$sampled(lost), $sampled(exp_lost));
		errors++;
	end

	initial
	begin
		#(limit_cycles * 4);
		$display("Timeout: run did not finish within %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		seed = 69854;
		errors = 0;
		read_count = 0;
		lost_count = 0;
		rst = 1'b1;
		motion_update_enable = 1'b0;
		in_valid = 1'b0;
		in_pos = '0;
		rd_en = 1'b0;
		rd_cell = '0;
		rd_addr = '0;
		exp_issue = '0;
		oob_issue = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);
		for (int r = 0; r < rounds; r++)
		begin
			run_round(r);
		end
		repeat (3) @(negedge clk);
		if (lost_count == 0)
		begin
			$display("No out-of-grid particle was sent, lost was never exercised");
			errors++;
		end
		$display("Summary: %0d reads, %0d lost particles, %0d errors",
			read_count, lost_count, errors);
		if (errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
source/md_pkg.sv
source/cell_ram.sv
source/pos_cache.sv
source/cell_router.sv
source/pos_read_port.sv
source/pos_cache_grid.sv
tests/pos_cache_grid_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module pos_cache_grid_tb -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vpos_cache_grid_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
	echo "Simulation reported errors, see $log"
	exit 1
fi

echo "Simulation finished without errors"
exit 0
